// ==== src/rv_pkg.sv ====
package rv_pkg;

  // ======================================================================
  // widths
  // ======================================================================

  localparam int xlen         = 32;
  localparam int reg_addr_w   = 5;
  localparam int num_regs     = 32;
  localparam int retire_cnt_w = 32;

  // shift amount taken from the low bits of operand b
  localparam int shamt_w      = $clog2(xlen);

  // ======================================================================
  // opcodes and funct3 codes
  // ======================================================================

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // encoded as {funct7[5], funct3} where it applies
  typedef enum logic [3:0] {
    alu_add    = 4'b0000,
    alu_sll    = 4'b0001,
    alu_slt    = 4'b0010,
    alu_sltu   = 4'b0011,
    alu_xor    = 4'b0100,
    alu_srl    = 4'b0101,
    alu_or     = 4'b0110,
    alu_and    = 4'b0111,
    alu_sub    = 4'b1000,
    alu_sra    = 4'b1101,
    alu_pass_b = 4'b1111
  } alu_op_t;

  // ======================================================================
  // stage payloads
  // ======================================================================

  typedef struct packed {
    logic [xlen-1:0] inst;
  } if_id_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [xlen-1:0]       imm;
    alu_op_t               alu_op;
    logic                  use_imm;
  } id_exe_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       result;
  } exe_wb_t;

  // writeback hit on a source register, never for x0
  function automatic logic wb_match(
    input logic                  wb_valid,
    input exe_wb_t               wb,
    input logic [reg_addr_w-1:0] rs
  );
    return wb_valid && (wb.rd != '0) && (wb.rd == rs);
  endfunction

endpackage

// ==== src/pipe_stage_reg.sv ====
`timescale 1ns/1ps

module pipe_stage_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // valid bit is the only control state here
  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // payload captured every cycle, qualified by valid downstream
  always_ff @(posedge clk) begin
    data_o <= data_i;
  end

endmodule

// ==== src/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          we_i,
  input  logic [rv_pkg::reg_addr_w-1:0] waddr_i,
  input  logic [rv_pkg::xlen-1:0]       wdata_i,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr1_i,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr2_i,
  output logic [rv_pkg::xlen-1:0]       rdata1_o,
  output logic [rv_pkg::xlen-1:0]       rdata2_o
);
  import rv_pkg::*;

  logic [xlen-1:0] regs [num_regs];

  // architectural state starts at zero
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero whatever the array holds
  always_comb begin
    if (raddr1_i == '0) begin
      rdata1_o = '0;
    end else begin
      rdata1_o = regs[raddr1_i];
    end
    if (raddr2_i == '0) begin
      rdata2_o = '0;
    end else begin
      rdata2_o = regs[raddr2_i];
    end
  end

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            valid_i,
  input  rv_pkg::if_id_t  inst_i,
  input  logic            wb_valid_i,
  input  rv_pkg::exe_wb_t wb_i,
  output logic            valid_o,
  output rv_pkg::id_exe_t id_exe_o
);
  import rv_pkg::*;

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic                  funct7_b5;
  logic [reg_addr_w-1:0] rs1_field;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic                  is_op;
  logic                  is_op_imm;
  logic                  is_lui;
  logic [xlen-1:0]       imm_i;
  logic [xlen-1:0]       imm_u;
  logic [xlen-1:0]       rf_rdata1;
  logic [xlen-1:0]       rf_rdata2;
  alu_op_t               alu_op;

  // ======================================================================
  // field extraction
  // ======================================================================

  assign opcode    = inst_i.inst[6:0];
  assign rd        = inst_i.inst[11:7];
  assign funct3    = inst_i.inst[14:12];
  assign rs1_field = inst_i.inst[19:15];
  assign rs2       = inst_i.inst[24:20];
  assign funct7_b5 = inst_i.inst[30];

  assign is_op     = (opcode == opc_op);
  assign is_op_imm = (opcode == opc_op_imm);
  assign is_lui    = (opcode == opc_lui);

  // lui has no rs1, upper bits there belong to the immediate
  assign rs1 = is_lui ? '0 : rs1_field;

  // unknown opcodes die here
  assign valid_o = valid_i && (is_op || is_op_imm || is_lui);

  // i-type sign extended, u-type in the upper bits
  assign imm_i = {{(xlen-12){inst_i.inst[31]}}, inst_i.inst[31:20]};
  assign imm_u = {inst_i.inst[31:12], 12'b0};

  // ======================================================================
  // alu op decode
  // ======================================================================

  always_comb begin
    if (is_lui) begin
      alu_op = alu_pass_b;
    end else begin
      case (funct3)
        f3_add_sub: alu_op = (is_op && funct7_b5) ? alu_sub : alu_add;
        f3_sll:     alu_op = alu_sll;
        f3_slt:     alu_op = alu_slt;
        f3_sltu:    alu_op = alu_sltu;
        f3_xor:     alu_op = alu_xor;
        f3_srl_sra: alu_op = funct7_b5 ? alu_sra : alu_srl;
        f3_or:      alu_op = alu_or;
        f3_and:     alu_op = alu_and;
        default:    alu_op = alu_add;
      endcase
    end
  end

  reg_file u_reg_file (
    .clk      (clk),
    .reset_i  (reset_i),
    .we_i     (wb_valid_i),
    .waddr_i  (wb_i.rd),
    .wdata_i  (wb_i.result),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2)
  );

  // writeback lands in the array one edge too late for this read
  always_comb begin
    id_exe_o.rs1     = rs1;
    id_exe_o.rs2     = rs2;
    id_exe_o.rd      = rd;
    id_exe_o.rdata1  = wb_match(wb_valid_i, wb_i, rs1) ? wb_i.result : rf_rdata1;
    id_exe_o.rdata2  = wb_match(wb_valid_i, wb_i, rs2) ? wb_i.result : rf_rdata2;
    id_exe_o.imm     = is_lui ? imm_u : imm_i;
    id_exe_o.alu_op  = alu_op;
    id_exe_o.use_imm = is_op_imm || is_lui;
  end

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  rv_pkg::id_exe_t id_exe_i,
  input  logic            wb_valid_i,
  input  rv_pkg::exe_wb_t wb_i,
  output rv_pkg::exe_wb_t exe_wb_o
);
  import rv_pkg::*;

  logic [xlen-1:0]    op_a;
  logic [xlen-1:0]    fwd_b;
  logic [xlen-1:0]    op_b;
  logic [shamt_w-1:0] shamt;
  logic [xlen-1:0]    alu_result;

  // instruction directly ahead is sitting in writeback
  assign op_a  = wb_match(wb_valid_i, wb_i, id_exe_i.rs1) ? wb_i.result
                                                          : id_exe_i.rdata1;
  assign fwd_b = wb_match(wb_valid_i, wb_i, id_exe_i.rs2) ? wb_i.result
                                                          : id_exe_i.rdata2;

  // immediate replaces rs2 for i-type and lui
  assign op_b  = id_exe_i.use_imm ? id_exe_i.imm : fwd_b;
  assign shamt = op_b[shamt_w-1:0];

  always_comb begin
    case (id_exe_i.alu_op)
      alu_add:  alu_result = op_a + op_b;
      alu_sub:  alu_result = op_a - op_b;
      alu_sll:  alu_result = op_a << shamt;
      alu_slt: begin
        alu_result = {{(xlen-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
      end
      alu_sltu: begin
        alu_result = {{(xlen-1){1'b0}}, (op_a < op_b)};
      end
      alu_xor:  alu_result = op_a ^ op_b;
      alu_srl:  alu_result = op_a >> shamt;
      // arithmetic shift keeps the sign
      alu_sra:  alu_result = $unsigned($signed(op_a) >>> shamt);
      alu_or:   alu_result = op_a | op_b;
      alu_and:  alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      default:  alu_result = '0;
    endcase
  end

  assign exe_wb_o.rd     = id_exe_i.rd;
  assign exe_wb_o.result = alu_result;

endmodule

// ==== src/retire_counter.sv ====
`timescale 1ns/1ps

module retire_counter (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic                            retire_i,
  output logic [rv_pkg::retire_cnt_w-1:0] count_o
);

  // wraps naturally at the top of the range
  always_ff @(posedge clk) begin
    if (reset_i) begin
      count_o <= '0;
    end else if (retire_i) begin
      count_o <= count_o + 1'b1;
    end
  end

endmodule

// ==== src/rv_lite_core.sv ====
`timescale 1ns/1ps

module rv_lite_core (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic                            inst_valid_i,
  input  logic [rv_pkg::xlen-1:0]         inst_i,
  output logic                            wb_valid_o,
  output logic [rv_pkg::reg_addr_w-1:0]   wb_rd_o,
  output logic [rv_pkg::xlen-1:0]         wb_data_o,
  output logic [rv_pkg::retire_cnt_w-1:0] retire_count_o
);
  import rv_pkg::*;

  if_id_t  fetch_d;
  if_id_t  fetch_q;
  logic    fetch_valid_q;
  id_exe_t dec_d;
  id_exe_t dec_q;
  logic    dec_valid_d;
  logic    dec_valid_q;
  exe_wb_t exe_d;
  exe_wb_t wb_q;
  logic    wb_valid_q;

  assign fetch_d.inst = inst_i;

  // ======================================================================
  // fetch / decode
  // ======================================================================

  pipe_stage_reg #(.payload_t(if_id_t)) u_if_id (
    .clk     (clk),
    .reset_i (reset_i),
    .valid_i (inst_valid_i),
    .data_i  (fetch_d),
    .valid_o (fetch_valid_q),
    .data_o  (fetch_q)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset_i    (reset_i),
    .valid_i    (fetch_valid_q),
    .inst_i     (fetch_q),
    .wb_valid_i (wb_valid_q),
    .wb_i       (wb_q),
    .valid_o    (dec_valid_d),
    .id_exe_o   (dec_d)
  );

  // ======================================================================
  // decode / execute
  // ======================================================================

  pipe_stage_reg #(.payload_t(id_exe_t)) u_id_exe (
    .clk     (clk),
    .reset_i (reset_i),
    .valid_i (dec_valid_d),
    .data_i  (dec_d),
    .valid_o (dec_valid_q),
    .data_o  (dec_q)
  );

  execute_stage u_execute (
    .id_exe_i   (dec_q),
    .wb_valid_i (wb_valid_q),
    .wb_i       (wb_q),
    .exe_wb_o   (exe_d)
  );

  // ======================================================================
  // execute / writeback
  // ======================================================================

  pipe_stage_reg #(.payload_t(exe_wb_t)) u_exe_wb (
    .clk     (clk),
    .reset_i (reset_i),
    .valid_i (dec_valid_q),
    .data_i  (exe_d),
    .valid_o (wb_valid_q),
    .data_o  (wb_q)
  );

  retire_counter u_retire (
    .clk      (clk),
    .reset_i  (reset_i),
    .retire_i (wb_valid_q),
    .count_o  (retire_count_o)
  );

  // writeback bus straight out
  assign wb_valid_o = wb_valid_q;
  assign wb_rd_o    = wb_q.rd;
  assign wb_data_o  = wb_q.result;

endmodule

// ==== testbench/rv_lite_props.sv ====
`timescale 1ns/1ps

module rv_lite_props (
  input logic                            clk,
  input logic                            reset_i,
  input logic                            wb_valid_i,
  input logic [rv_pkg::xlen-1:0]         wb_data_i,
  input logic [rv_pkg::retire_cnt_w-1:0] retire_count_i
);
  import rv_pkg::*;

  // writeback is quiet right after reset
  a_reset_quiet: assert property (@(posedge clk) reset_i |=> !wb_valid_i)
    else $error("writeback valid high in the cycle after reset");

  // one retire per valid writeback cycle
  a_retire_step: assert property (@(posedge clk) disable iff (reset_i)
    wb_valid_i |=> (retire_count_i == $past(retire_count_i) + 1'b1))
    else $error("retire count did not step by one after a writeback");

  a_retire_hold: assert property (@(posedge clk) disable iff (reset_i)
    !wb_valid_i |=> (retire_count_i == $past(retire_count_i)))
    else $error("retire count changed without a writeback");

  // no x or z on the result bus while it is valid
  a_wb_known: assert property (@(posedge clk) disable iff (reset_i)
    wb_valid_i |-> !$isunknown(wb_data_i))
    else $error("writeback data has unknown bits while valid");

endmodule

// ==== testbench/rv_lite_tb.sv ====
`timescale 1ns/1ps

module rv_lite_tb;
  import rv_pkg::*;

  localparam int max_cycles = 600;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    logic [31:0]           capture;
  } exp_t;

  logic                    clk = 1'b0;
  logic                    reset_i;
  logic                    inst_valid_i;
  logic [xlen-1:0]         inst_i;
  logic                    wb_valid_o;
  logic [reg_addr_w-1:0]   wb_rd_o;
  logic [xlen-1:0]         wb_data_o;
  logic [retire_cnt_w-1:0] retire_count_o;

  logic [xlen-1:0] ref_regs [num_regs];
  exp_t            exp_q [$];
  int              seed = 45;
  int              error_count = 0;
  int              check_count = 0;
  int              issued_valid = 0;
  logic [31:0]     cycle_count = 0;
  // {funct7[5], funct3} for the ten register ops
  logic [3:0]      r_ops [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};

  rv_lite_core i_dut (
    .clk            (clk),
    .reset_i        (reset_i),
    .inst_valid_i   (inst_valid_i),
    .inst_i         (inst_i),
    .wb_valid_o     (wb_valid_o),
    .wb_rd_o        (wb_rd_o),
    .wb_data_o      (wb_data_o),
    .retire_count_o (retire_count_o)
  );

  bind rv_lite_core rv_lite_props u_props (
    .clk            (clk),
    .reset_i        (reset_i),
    .wb_valid_i     (wb_valid_o),
    .wb_data_i      (wb_data_o),
    .retire_count_i (retire_count_o)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == max_cycles) begin
      $display("run timed out after %0d cycles with %0d results outstanding",
               cycle_count, exp_q.size());
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ======================================================================
  // encoders and reference model
  // ======================================================================

  function automatic logic [31:0] encode_r(input logic [3:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
    return {1'b0, op[3], 5'b0, rs2, rs1, op[2:0], rd, opc_op};
  endfunction

  function automatic logic [31:0] encode_i(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc_op_imm};
  endfunction

  function automatic logic [31:0] encode_u(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, opc_lui};
  endfunction

  // result by the rv32i rules from the reference registers
  function automatic logic [xlen-1:0] ref_result(input logic [31:0] inst);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [4:0]      sh;
    a = ref_regs[inst[19:15]];
    b = (inst[6:0] == opc_op) ? ref_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
    sh = b[4:0];
    if (inst[6:0] == opc_lui) return {inst[31:12], 12'b0};
    case (inst[14:12])
      3'd0: return (inst[6:0] == opc_op && inst[30]) ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return ($signed(a) < $signed(b)) ? 1 : 0;
      3'd3: return (a < b) ? 1 : 0;
      3'd4: return a ^ b;
      3'd5: return inst[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [xlen-1:0] actual,
                             input logic [xlen-1:0] expected);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // drive one instruction strobe and queue its expected writeback
  task automatic send(input logic [31:0] inst);
    exp_t e;
    @(negedge clk);
    inst_valid_i = 1'b1;
    inst_i = inst;
    if (inst[6:0] inside {opc_op, opc_op_imm, opc_lui}) begin
      e.rd = inst[11:7];
      e.data = ref_result(inst);
      e.capture = cycle_count + 1;
      exp_q.push_back(e);
      if (e.rd != 0) ref_regs[e.rd] = e.data;
      issued_valid++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      inst_valid_i = 1'b0;
      inst_i = $random(seed);
    end
  endtask

  task automatic drain();
    @(negedge clk);
    inst_valid_i = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    // room for a stray writeback and the last counter update
    repeat (2) @(negedge clk);
  endtask

  // pop and check one expected result per valid writeback
  always @(negedge clk) begin : monitor
    exp_t e;
    if (!reset_i && wb_valid_o) begin
      if (exp_q.size() == 0) begin
        error_count++;
        $display("writeback at t=%0t with no instruction outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        check_value("wb_rd_o", wb_rd_o, e.rd);
        check_value("wb_data_o", wb_data_o, e.data);
        assert (cycle_count - e.capture == 2) else begin
          error_count++;
          $display("result for x%0d arrived %0d cycles after capture instead of 2",
                   e.rd, cycle_count - e.capture);
        end
      end
    end
  end

  // ======================================================================
  // directed tests
  // ======================================================================

  task automatic test_reset_state();
    repeat (4) begin
      @(negedge clk);
      check_value("wb_valid_o", wb_valid_o, 0);
      check_value("retire_count_o", retire_count_o, 0);
    end
    // fresh registers read zero
    send(encode_r(4'h0, 5'd9, 5'd10, 5'd11));
    send(encode_r(4'h6, 5'd12, 5'd0, 5'd13));
    drain();
  endtask

  task automatic test_imm_ops();
    send(encode_u(5'd1, 20'h80f0f));
    send(encode_u(5'd2, 20'h00ff3));
    idle(3);
    send(encode_i(3'd0, 5'd3, 5'd1, 12'h7ff));
    send(encode_i(3'd2, 5'd4, 5'd2, 12'hfff));
    send(encode_i(3'd3, 5'd5, 5'd1, 12'h800));
    send(encode_i(3'd4, 5'd6, 5'd2, 12'h5a5));
    send(encode_i(3'd6, 5'd7, 5'd1, 12'h0f0));
    send(encode_i(3'd7, 5'd8, 5'd2, 12'hf0f));
    send(encode_i(3'd1, 5'd9, 5'd1, 12'h004));
    send(encode_i(3'd5, 5'd10, 5'd1, 12'h007));
    send(encode_i(3'd5, 5'd11, 5'd1, {7'b0100000, 5'd9}));
    send(encode_u(5'd12, 20'habcde));
    drain();
  endtask

  task automatic test_dep_chains();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 40; i++) begin
      a = $random(seed);
      b = $random(seed);
      send(encode_u(5'd1, a[31:12]));
      send(encode_i(3'd0, 5'd1, 5'd1, a[11:0]));
      send(encode_u(5'd2, b[31:12]));
      send(encode_i(3'd0, 5'd2, 5'd2, b[11:0]));
      // one ahead through execute, two ahead through decode bypass
      send(encode_r(r_ops[i % 10], 5'd3, 5'd1, 5'd2));
      send(encode_r(r_ops[(i + 1) % 10], 5'd4, 5'd3, 5'd2));
      send(encode_r(r_ops[(i + 2) % 10], 5'd5, 5'd4, 5'd3));
    end
    drain();
  endtask

  task automatic test_x0();
    send(encode_i(3'd0, 5'd0, 5'd0, 12'd123));
    send(encode_r(4'h0, 5'd13, 5'd0, 5'd0));
    send(encode_u(5'd0, 20'hfffff));
    send(encode_r(4'h0, 5'd14, 5'd0, 5'd13));
    send(encode_r(4'h6, 5'd15, 5'd0, 5'd0));
    idle(2);
    send(encode_r(4'h0, 5'd16, 5'd0, 5'd0));
    drain();
  endtask

  task automatic test_bad_opcodes();
    send(32'h0000_2083);
    idle(2);
    send(encode_i(3'd0, 5'd17, 5'd0, 12'd33));
    send(32'h0020_8463);
    send(32'hffff_ffff);
    idle(3);
    send(encode_r(4'h0, 5'd18, 5'd17, 5'd17));
    send(32'h0011_2023);
    drain();
    check_value("retire_count_o", retire_count_o, issued_valid);
  endtask

  initial begin
    reset_i = 1'b1;
    inst_valid_i = 1'b0;
    inst_i = '0;
    for (int i = 0; i < num_regs; i++) ref_regs[i] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    test_reset_state();
    test_imm_ops();
    test_dep_chains();
    test_x0();
    test_bad_opcodes();
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== rv_lite.f ====
src/rv_pkg.sv
src/pipe_stage_reg.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/retire_counter.sv
src/rv_lite_core.sv
testbench/rv_lite_props.sv
testbench/rv_lite_tb.sv
